/* all.f */
+incdir+design
design/gb80_irq_pkg.sv
design/irq_axil_port.sv
design/irq_flag_regs.sv
design/irq_priority.sv
design/gb80_irq.sv
testbench/gb80_irq_checker.sv
testbench/gb80_irq_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= gb80_irq_tb
BUILD_DIR ?= build
LOG       ?= sim.log

FILE_LIST := all.f
SOURCES   := $(shell grep -v '^+' $(FILE_LIST))
HEADERS   := design/gb80_irq_config.svh
BINARY    := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BINARY): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) --binary --timing --assert -f $(FILE_LIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

$(LOG): $(BINARY)
	$(BINARY) > $(LOG) 2>&1 || true
	cat $(LOG)

run: $(LOG)

check: run
	@grep -q "Simulation PASSED" $(LOG) && echo "Result: pass" || \
		(echo "Result: fail"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/gb80_irq_tb.sv */
`timescale 1ns/100ps
`include "gb80_irq_config.svh"

module gb80_irq_tb import gb80_irq_pkg::*; ();

   localparam int MAX_STALL = 7;
   localparam int N_ACCESS  = 80;
   localparam int N_PULSE   = 40;
   localparam int TIMEOUT   = 16 + N_ACCESS * (8 + MAX_STALL) + N_PULSE * 4 + 200;

   logic                   clock;
   logic                   reset;
   axil_req_s              req;
   axil_rsp_s              rsp;
   logic [`GB80_IRQ_N-1:0] irq_request;
   logic                   irq_ack;
   logic                   irq_pending;
   logic [7:0]             irq_vector;

   logic [31:0]            lfsr_state = 32'hef6c;
   logic [4:0]             m_if;
   logic [4:0]             m_ie;
   logic                   m_ime;
   logic                   stall_on;
   int                     errors;
   int                     checks;
   int                     test_errors;
   int                     cycles;

   gb80_irq gb80_irq_inst (
      .clock       (clock),
      .reset       (reset),
      .axil_req    (req),
      .axil_rsp    (rsp),
      .irq_request (irq_request),
      .irq_ack     (irq_ack),
      .irq_pending (irq_pending),
      .irq_vector  (irq_vector)
   );

   always #5 clock = ~clock;

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Expected {pending, vector} from IF, IE and IME
   function automatic logic [8:0] ref_irq(input logic [4:0] f, input logic [4:0] e,
                                          input logic ime);
      logic [7:0] vec;
      logic       found;
      vec = 8'h40;
      found = 1'b0;
      for (int i = 0; i < 5; i++) begin
         if (!found && f[i] && e[i]) begin
            found = 1'b1;
            vec = 8'h40 + 8'(8 * i);
         end
      end
      return {ime & found, vec};
   endfunction

   function automatic logic [4:0] lowest_bit(input logic [4:0] v);
      return v & (~v + 5'd1);
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      checks++;
      if (exp !== got) begin
         $display("MISMATCH %s expected %h got %h at %0t", name, exp, got, $time);
         errors++;
      end
   endtask

   // Register model follows the DUT inputs seen at each edge
   always @(posedge clock) begin
      logic [8:0] r;
      logic [4:0] base;
      logic       wr;
      if (reset) begin
         m_if = '0;
         m_ie = '0;
         m_ime = 1'b1;
      end else begin
         r = ref_irq(m_if, m_ie, m_ime);
         wr = rsp.awready && req.awvalid && req.wvalid && req.wstrb[0];
         base = m_if & ~((irq_ack && r[8]) ? lowest_bit(m_if & m_ie) : 5'd0);
         if (wr && req.awaddr == 4'h0) base = req.wdata[4:0];
         m_if = base | irq_request;
         if (wr && req.awaddr == 4'h4) m_ie = req.wdata[4:0];
         if (wr && req.awaddr == 4'h8) m_ime = req.wdata[0];
         else if (irq_ack && r[8]) m_ime = 1'b0;
      end
   end

   // Compare process, outputs settled mid cycle
   always @(negedge clock) begin
      logic [8:0] r;
      if (!reset) begin
         r = ref_irq(m_if, m_ie, m_ime);
         if (irq_pending !== r[8]) check_value("irq_pending", r[8], irq_pending);
         if (irq_vector !== r[7:0]) check_value("irq_vector", r[7:0], irq_vector);
         checks++;
      end
   end

   always @(posedge clock) begin
      cycles++;
      if (cycles > TIMEOUT) begin
         $display("Timeout: no finish within %0d cycles, handshake stuck", TIMEOUT);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      int stall;
      stall = stall_on ? int'(rand_bits(3)) : 0;
      req.awvalid <= 1'b1;
      req.wvalid <= 1'b1;
      req.awaddr <= addr;
      req.wdata <= data;
      req.wstrb <= strb;
      do @(posedge clock); while (!rsp.awready);
      check_value("wready", 32'h1, 32'(rsp.wready));
      // Under back-pressure the same write is offered again and has to wait
      req.awvalid <= (stall > 0);
      req.wvalid <= (stall > 0);
      do @(posedge clock); while (!rsp.bvalid);
      repeat (stall) begin
         @(posedge clock);
         if (!rsp.bvalid) begin
            $display("bvalid dropped before bready at %0t", $time);
            errors++;
         end
         if (rsp.awready || rsp.wready) begin
            $display("write accepted while bvalid was high at %0t", $time);
            errors++;
         end
      end
      check_value("bresp", 32'(2'b00), 32'(rsp.bresp));
      req.awvalid <= 1'b0;
      req.wvalid <= 1'b0;
      req.bready <= 1'b1;
      @(posedge clock);
      req.bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
      int stall;
      stall = stall_on ? int'(rand_bits(3)) : 0;
      req.arvalid <= 1'b1;
      req.araddr <= addr;
      do @(posedge clock); while (!rsp.arready);
      // Under back-pressure the same read is offered again and has to wait
      req.arvalid <= (stall > 0);
      do @(posedge clock); while (!rsp.rvalid);
      data = rsp.rdata;
      repeat (stall) begin
         @(posedge clock);
         if (!rsp.rvalid) begin
            $display("rvalid dropped before rready at %0t", $time);
            errors++;
         end
         if (rsp.arready) begin
            $display("read accepted while rvalid was high at %0t", $time);
            errors++;
         end
         check_value("rdata held", data, rsp.rdata);
      end
      check_value("rresp", 32'(2'b00), 32'(rsp.rresp));
      req.arvalid <= 1'b0;
      req.rready <= 1'b1;
      @(posedge clock);
      req.rready <= 1'b0;
   endtask

   task automatic read_expect(input string name, input logic [3:0] addr,
                              input logic [31:0] exp);
      logic [31:0] got;
      axil_read(addr, got);
      check_value(name, exp, got);
   endtask

   task automatic end_test(input string name);
      $display("Test %s: %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   // Random registers, request pulses and reads against the model
   task automatic run_traffic(input int n);
      logic [31:0] v;
      for (int i = 0; i < n; i++) begin
         v = rand_bits(32);
         axil_write(4'h4, v, 4'hf);
         read_expect("IE", 4'h4, {27'd0, v[4:0]});
         @(posedge clock);
         irq_request <= 5'(rand_bits(5));
         @(posedge clock);
         irq_request <= '0;
         @(posedge clock);
         read_expect("IF", 4'h0, {27'd0, m_if});
      end
   endtask

   initial begin
      logic [31:0] v;
      logic [4:0]  exp_if;
      clock = 1'b0;
      reset = 1'b1;
      req = '0;
      irq_request = '0;
      irq_ack = 1'b0;
      stall_on = 1'b0;
      repeat (16) @(posedge clock);
      reset <= 1'b0;
      @(posedge clock);

      read_expect("IF", 4'h0, 32'h0);
      read_expect("IE", 4'h4, 32'h0);
      read_expect("IME", 4'h8, 32'h1);
      check_value("irq_pending", 32'h0, 32'(irq_pending));
      end_test("reset values");

      for (int i = 0; i < 4; i++) begin
         v = rand_bits(32);
         axil_write(4'h0, v, 4'hf);
         read_expect("IF", 4'h0, {27'd0, v[4:0]});
         v = rand_bits(32);
         axil_write(4'h4, v, 4'hf);
         read_expect("IE", 4'h4, {27'd0, v[4:0]});
         v = rand_bits(32);
         axil_write(4'h8, v, 4'hf);
         read_expect("IME", 4'h8, {31'd0, v[0]});
      end
      axil_write(4'hc, 32'hffff_ffff, 4'hf);
      read_expect("unmapped", 4'hc, 32'h0);
      axil_write(4'h4, ~{27'd0, m_ie}, 4'he);
      read_expect("IE strobe", 4'h4, {27'd0, m_ie});
      end_test("register access");

      axil_write(4'h8, 32'h1, 4'hf);
      axil_write(4'h0, 32'h0, 4'hf);
      run_traffic(N_PULSE / 4);
      end_test("request priority");

      axil_write(4'h4, 32'h1f, 4'hf);
      axil_write(4'h0, 32'h1f, 4'hf);
      axil_write(4'h8, 32'h1, 4'hf);
      while (m_if != 0) begin
         exp_if = m_if & ~lowest_bit(m_if & m_ie);
         irq_ack <= 1'b1;
         @(posedge clock);
         irq_ack <= 1'b0;
         @(negedge clock);
         check_value("irq_pending after ack", 32'h0, 32'(irq_pending));
         @(posedge clock);
         read_expect("IF after ack", 4'h0, {27'd0, exp_if});
         read_expect("IME after ack", 4'h8, 32'h0);
         axil_write(4'h8, 32'h1, 4'hf);
      end
      end_test("acknowledge");

      stall_on = 1'b1;
      run_traffic(N_PULSE / 4);
      end_test("back-pressure");

      $display("Done: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* testbench/gb80_irq_checker.sv */
`timescale 1ns/100ps
`include "gb80_irq_config.svh"

module gb80_irq_checker import gb80_irq_pkg::*; (
   input logic      clock,
   input logic      reset,
   input axil_req_s axil_req,
   input axil_rsp_s axil_rsp
);

   // Write response held until taken
   assert property (@(posedge clock) disable iff (reset)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
      else $error("bvalid or bresp changed before bready");

   // Read data held until taken
   assert property (@(posedge clock) disable iff (reset)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
      else $error("rvalid or rdata changed before rready");

   // One write outstanding at most
   assert property (@(posedge clock) disable iff (reset)
      axil_rsp.bvalid |-> !axil_rsp.awready)
      else $error("awready high with a write response pending");

endmodule

bind gb80_irq gb80_irq_checker checker_inst (
   .clock    (clock),
   .reset    (reset),
   .axil_req (axil_req),
   .axil_rsp (axil_rsp)
);

/* design/gb80_irq.sv */
`timescale 1ns/100ps
`include "gb80_irq_config.svh"

module gb80_irq import gb80_irq_pkg::*; (
   input  logic                   clock,
   input  logic                   reset,
   input  axil_req_s              axil_req,
   output axil_rsp_s              axil_rsp,
   input  logic [`GB80_IRQ_N-1:0] irq_request,
   input  logic                   irq_ack,
   output logic                   irq_pending,
   output logic [7:0]             irq_vector
);

   reg_write_s             reg_write;
   irq_state_s             irq_state;
   logic [`GB80_IRQ_N-1:0] irq_clear_mask;
   logic                   irq_taken;

   // Software access to IF, IE and IME
   irq_axil_port port_inst (
      .clock     (clock),
      .reset     (reset),
      .axil_req  (axil_req),
      .axil_rsp  (axil_rsp),
      .reg_write (reg_write),
      .irq_state (irq_state)
   );

   irq_flag_regs regs_inst (
      .clock          (clock),
      .reset          (reset),
      .reg_write      (reg_write),
      .irq_request    (irq_request),
      .irq_clear_mask (irq_clear_mask),
      .irq_taken      (irq_taken),
      .irq_state      (irq_state)
   );

   // Acknowledge feeds back into the flags at the same edge
   irq_priority prio_inst (
      .irq_state      (irq_state),
      .irq_ack        (irq_ack),
      .irq_pending    (irq_pending),
      .irq_vector     (irq_vector),
      .irq_clear_mask (irq_clear_mask),
      .irq_taken      (irq_taken)
   );

endmodule

/* design/irq_priority.sv */
`timescale 1ns/100ps
`include "gb80_irq_config.svh"

module irq_priority import gb80_irq_pkg::*; (
   input  irq_state_s             irq_state,
   input  logic                   irq_ack,
   output logic                   irq_pending,
   output logic [7:0]             irq_vector,
   output logic [`GB80_IRQ_N-1:0] irq_clear_mask,
   output logic                   irq_taken
);

   logic [`GB80_IRQ_N-1:0] active;
   logic [2:0]             sel_index;

   assign active = irq_state.if_bits.bits & irq_state.ie_bits.bits;

   // Scan from the top so the lowest set bit is written last
   always_comb begin
      sel_index = 3'd0;
      for (int i = `GB80_IRQ_N - 1; i >= 0; i--) begin
         if (active[i]) begin
            sel_index = 3'(i);
         end
      end
   end

   assign irq_pending = irq_state.ime & (|active);
   assign irq_taken   = irq_ack & irq_pending;

   // Index 0 with nothing active lands on the base vector
   assign irq_vector = 8'(`GB80_VEC_BASE + `GB80_VEC_STEP * sel_index);

   // Only the served source is cleared
   always_comb begin
      if (irq_taken) begin
         irq_clear_mask = {{(`GB80_IRQ_N-1){1'b0}}, 1'b1} << sel_index;
      end else begin
         irq_clear_mask = '0;
      end
   end

endmodule

/* design/irq_flag_regs.sv */
`timescale 1ns/100ps
`include "gb80_irq_config.svh"

module irq_flag_regs import gb80_irq_pkg::*; (
   input  logic                   clock,
   input  logic                   reset,
   input  reg_write_s             reg_write,
   input  logic [`GB80_IRQ_N-1:0] irq_request,
   input  logic [`GB80_IRQ_N-1:0] irq_clear_mask,
   input  logic                   irq_taken,
   output irq_state_s             irq_state
);

   logic [`GB80_IRQ_N-1:0] if_q;
   logic [`GB80_IRQ_N-1:0] ie_q;
   logic                   ime_q;
   logic [`GB80_IRQ_N-1:0] if_base;
   logic [`GB80_IRQ_N-1:0] if_next;
   logic [`GB80_IRQ_N-1:0] ie_next;
   logic                   ime_next;

   always_comb begin
      // Bus write replaces IF, otherwise the served bit drops
      if (reg_write.valid && reg_write.sel_if) begin
         if_base = reg_write.data;
      end else begin
         if_base = if_q & ~irq_clear_mask;
      end
      // Requests land last so none is lost
      if_next = if_base | irq_request;

      ie_next = (reg_write.valid && reg_write.sel_ie) ? reg_write.data : ie_q;

      // Software write wins over the acknowledge
      if (reg_write.valid && reg_write.sel_ime) begin
         ime_next = reg_write.data[0];
      end else if (irq_taken) begin
         ime_next = 1'b0;
      end else begin
         ime_next = ime_q;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q  <= '0;
         ie_q  <= '0;
         ime_q <= 1'b1;
      end else begin
         if_q  <= if_next;
         ie_q  <= ie_next;
         ime_q <= ime_next;
      end
   end

   assign irq_state.if_bits.bits = if_q;
   assign irq_state.ie_bits.bits = ie_q;
   assign irq_state.ime          = ime_q;

endmodule

/* design/irq_axil_port.sv */
`timescale 1ns/100ps
`include "gb80_irq_config.svh"

module irq_axil_port import gb80_irq_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  axil_req_s  axil_req,
   output axil_rsp_s  axil_rsp,
   output reg_write_s reg_write,
   input  irq_state_s irq_state
);

   localparam logic [1:0] RESP_OKAY = 2'b00;

   logic                     wr_accept;
   logic                     rd_accept;
   logic [2:0]               wr_sel;
   logic [2:0]               rd_sel;
   logic                     bvalid_q;
   logic                     rvalid_q;
   logic [`GB80_AXIL_DW-1:0] rd_word;
   logic [`GB80_AXIL_DW-1:0] rdata_q;

   // One-hot select {ime, ie, if}, zero when unmapped
   function automatic logic [2:0] decode_offset(input logic [`GB80_AXIL_AW-1:0] addr);
      case (addr)
         `GB80_OFS_IF:  decode_offset = 3'b001;
         `GB80_OFS_IE:  decode_offset = 3'b010;
         `GB80_OFS_IME: decode_offset = 3'b100;
         default:       decode_offset = 3'b000;
      endcase
   endfunction

   // Register map layout of a flag word
   function automatic logic [`GB80_AXIL_DW-1:0] flag_word(input irq_bits_u word);
      flag_word = '0;
      flag_word[`GB80_IRQ_N-1:0] = {word.flags.hilo,
                                    word.flags.serial,
                                    word.flags.tima,
                                    word.flags.lcdc,
                                    word.flags.vblank};
   endfunction

   // Address and data must arrive together, one response at a time
   assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
   assign rd_accept = axil_req.arvalid & ~rvalid_q;

   assign wr_sel = decode_offset(axil_req.awaddr);
   assign rd_sel = decode_offset(axil_req.araddr);

   always_comb begin
      // Byte 0 strobe carries every stored bit
      reg_write.valid   = wr_accept & axil_req.wstrb[0] & (|wr_sel);
      reg_write.sel_if  = wr_sel[0];
      reg_write.sel_ie  = wr_sel[1];
      reg_write.sel_ime = wr_sel[2];
      reg_write.data    = axil_req.wdata[`GB80_IRQ_N-1:0];
   end

   always_comb begin
      case (rd_sel)
         3'b001:  rd_word = flag_word(irq_state.if_bits);
         3'b010:  rd_word = flag_word(irq_state.ie_bits);
         3'b100:  rd_word = {{(`GB80_AXIL_DW-1){1'b0}}, irq_state.ime};
         default: rd_word = '0;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_accept) begin
            bvalid_q <= 1'b1;
         end else if (axil_req.bready) begin
            bvalid_q <= 1'b0;
         end
         if (rd_accept) begin
            rvalid_q <= 1'b1;
         end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // Read data captured at the handshake, held under back-pressure
   always_ff @(posedge clock) begin
      if (rd_accept) begin
         rdata_q <= rd_word;
      end
   end

   assign axil_rsp.awready = wr_accept;
   assign axil_rsp.wready  = wr_accept;
   assign axil_rsp.bvalid  = bvalid_q;
   assign axil_rsp.bresp   = RESP_OKAY;
   assign axil_rsp.arready = rd_accept;
   assign axil_rsp.rvalid  = rvalid_q;
   assign axil_rsp.rdata   = rdata_q;
   assign axil_rsp.rresp   = RESP_OKAY;

endmodule

/* design/gb80_irq_pkg.sv */
`include "gb80_irq_config.svh"

package gb80_irq_pkg;

   // Named interrupt sources, vblank in bit 0
   typedef struct packed {
      logic hilo;
      logic serial;
      logic tima;
      logic lcdc;
      logic vblank;
   } irq_flags_s;

   // Same word seen by name or by index
   typedef union packed {
      irq_flags_s               flags;
      logic [`GB80_IRQ_N-1:0]   bits;
   } irq_bits_u;

   typedef struct packed {
      irq_bits_u if_bits;
      irq_bits_u ie_bits;
      logic      ime;
   } irq_state_s;

   // Single cycle register write from the bus port
   typedef struct packed {
      logic                   valid;
      logic                   sel_if;
      logic                   sel_ie;
      logic                   sel_ime;
      logic [`GB80_IRQ_N-1:0] data;
   } reg_write_s;

   // AXI4-Lite master to slave
   typedef struct packed {
      logic                        awvalid;
      logic [`GB80_AXIL_AW-1:0]    awaddr;
      logic                        wvalid;
      logic [`GB80_AXIL_DW-1:0]    wdata;
      logic [`GB80_AXIL_DW/8-1:0]  wstrb;
      logic                        bready;
      logic                        arvalid;
      logic [`GB80_AXIL_AW-1:0]    araddr;
      logic                        rready;
   } axil_req_s;

   // AXI4-Lite slave to master
   typedef struct packed {
      logic                        awready;
      logic                        wready;
      logic                        bvalid;
      logic [1:0]                  bresp;
      logic                        arready;
      logic                        rvalid;
      logic [`GB80_AXIL_DW-1:0]    rdata;
      logic [1:0]                  rresp;
   } axil_rsp_s;

endpackage

/* design/gb80_irq_config.svh */
`ifndef GB80_IRQ_CONFIG_SVH
`define GB80_IRQ_CONFIG_SVH

// Interrupt sources: vblank, lcdc, tima, serial, hilo
`define GB80_IRQ_N 5

// AXI4-Lite bus geometry
`define GB80_AXIL_AW 4
`define GB80_AXIL_DW 32

// Register byte offsets
`define GB80_OFS_IF 4'h0
`define GB80_OFS_IE 4'h4
`define GB80_OFS_IME 4'h8

// Restart vectors start at 0x40, one every 8 bytes
`define GB80_VEC_BASE 8'h40
`define GB80_VEC_STEP 8

`endif
